// ==== src/mips_id_pkg.sv ====
package mips_id_pkg;

	localparam int XLEN_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 12;

	localparam logic [REG_ADDR_W-1:0] LINK_REG    = 5'd31;
	localparam logic [XLEN_W-1:0]     LINK_OFFSET = 32'd8; // return address is pc + 8

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_REGIMM  = 6'h01;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_BLEZ    = 6'h06;
	localparam logic [5:0] OP_BGTZ    = 6'h07;
	localparam logic [5:0] OP_ADDI    = 6'h08;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_SLTI    = 6'h0a;
	localparam logic [5:0] OP_SLTIU   = 6'h0b;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// SPECIAL funct codes
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_SLLV = 6'h04;
	localparam logic [5:0] FN_SRLV = 6'h06;
	localparam logic [5:0] FN_SRAV = 6'h07;
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// REGIMM codes live in the rt field
	localparam logic [4:0] RT_BLTZ   = 5'h00;
	localparam logic [4:0] RT_BGEZ   = 5'h01;
	localparam logic [4:0] RT_BLTZAL = 5'h10;
	localparam logic [4:0] RT_BGEZAL = 5'h11;

	// one-hot alu op bit positions
	localparam int AOP_ADD  = 0;
	localparam int AOP_SUB  = 1;
	localparam int AOP_SLT  = 2;
	localparam int AOP_SLTU = 3;
	localparam int AOP_AND  = 4;
	localparam int AOP_NOR  = 5;
	localparam int AOP_OR   = 6;
	localparam int AOP_XOR  = 7;
	localparam int AOP_SLL  = 8;
	localparam int AOP_SRL  = 9;
	localparam int AOP_SRA  = 10;
	localparam int AOP_LUI  = 11;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sa;
		logic [5:0] funct;
	} r_inst_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_inst_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_inst_t;

	typedef union packed {
		r_inst_t r_t;
		i_inst_t i_t;
		j_inst_t j_t;
	} mips_inst_u;

	typedef enum logic [3:0] {
		BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_J, BR_JR
	} br_kind_e;

	typedef struct packed {
		logic [ALU_OP_W-1:0] alu_op;
		logic                ren1;
		logic                ren2;
		logic                src1_sa;
		logic                src1_pc;
		logic                src2_imm_s;
		logic                src2_imm_u;
		logic                src2_link;
		logic                waddr_link;
		logic                waddr_rt;
		logic                wr_none;
		br_kind_e            br_kind;
		logic                is_link;
		logic                illegal;
		logic                valid;
	} id_ctrl_t;

	typedef struct packed {
		logic              taken;
		logic              is_branch;
		logic [XLEN_W-1:0] target;
	} br_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN_W-1:0]     pc;
		mips_inst_u            inst;
		logic [XLEN_W-1:0]     opr1;
		logic [XLEN_W-1:0]     opr2;
		logic [XLEN_W-1:0]     rtvalue;
		logic [REG_ADDR_W-1:0] waddr;
		logic                  wren;
		logic [ALU_OP_W-1:0]   alu_op;
		logic                  illegal;
	} id_ex_t;

endpackage

// ==== src/id_field_decode.sv ====
`timescale 1ns/1ns

module id_field_decode (
	input  mips_id_pkg::mips_inst_u inst_i,
	input  logic                    inst_valid_i,
	output mips_id_pkg::id_ctrl_t   ctrl_o
);
	import mips_id_pkg::*;

	logic     rs_zero;
	logic     rt_zero;
	logic     rd_zero;
	logic     sa_zero;
	logic     hit;
	id_ctrl_t ctrl;

	assign rs_zero = (inst_i.r_t.rs == '0);
	assign rt_zero = (inst_i.r_t.rt == '0);
	assign rd_zero = (inst_i.r_t.rd == '0);
	assign sa_zero = (inst_i.r_t.sa == '0);

	always_comb begin
		ctrl = '0;
		hit  = 1'b1;
		case (inst_i.r_t.opcode)
		OP_SPECIAL: begin
			ctrl.ren1 = 1'b1;
			ctrl.ren2 = 1'b1;
			hit = sa_zero;
			case (inst_i.r_t.funct)
			FN_ADD, FN_ADDU: ctrl.alu_op[AOP_ADD] = 1'b1; // no overflow trap here
			FN_SUB, FN_SUBU: ctrl.alu_op[AOP_SUB] = 1'b1;
			FN_SLT:          ctrl.alu_op[AOP_SLT] = 1'b1;
			FN_SLTU:         ctrl.alu_op[AOP_SLTU] = 1'b1;
			FN_AND:          ctrl.alu_op[AOP_AND] = 1'b1;
			FN_OR:           ctrl.alu_op[AOP_OR] = 1'b1;
			FN_XOR:          ctrl.alu_op[AOP_XOR] = 1'b1;
			FN_NOR:          ctrl.alu_op[AOP_NOR] = 1'b1;
			FN_SLL, FN_SLLV: ctrl.alu_op[AOP_SLL] = 1'b1;
			FN_SRL, FN_SRLV: ctrl.alu_op[AOP_SRL] = 1'b1;
			FN_SRA, FN_SRAV: ctrl.alu_op[AOP_SRA] = 1'b1;
			FN_JR: begin
				hit = sa_zero & rt_zero & rd_zero;
				ctrl.ren2 = 1'b0;
				ctrl.br_kind = BR_JR;
			end
			FN_JALR: begin
				hit = sa_zero & rt_zero;
				ctrl.ren2 = 1'b0;
				ctrl.br_kind = BR_JR;
				ctrl.is_link = 1'b1;
			end
			default: hit = 1'b0;
			endcase
			// constant shifts take sa, rs must be zero
			if (inst_i.r_t.funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
				hit = rs_zero;
				ctrl.ren1 = 1'b0;
				ctrl.src1_sa = 1'b1;
			end
		end
		OP_ADDI, OP_ADDIU: begin
			ctrl.alu_op[AOP_ADD] = 1'b1;
			ctrl.src2_imm_s = 1'b1;
		end
		OP_SLTI: begin
			ctrl.alu_op[AOP_SLT] = 1'b1;
			ctrl.src2_imm_s = 1'b1;
		end
		OP_SLTIU: begin
			ctrl.alu_op[AOP_SLTU] = 1'b1;
			ctrl.src2_imm_s = 1'b1; // sign extended, compared unsigned
		end
		OP_ANDI: begin
			ctrl.alu_op[AOP_AND] = 1'b1;
			ctrl.src2_imm_u = 1'b1;
		end
		OP_ORI: begin
			ctrl.alu_op[AOP_OR] = 1'b1;
			ctrl.src2_imm_u = 1'b1;
		end
		OP_XORI: begin
			ctrl.alu_op[AOP_XOR] = 1'b1;
			ctrl.src2_imm_u = 1'b1;
		end
		OP_LUI: begin
			hit = rs_zero;
			ctrl.alu_op[AOP_LUI] = 1'b1;
			ctrl.src2_imm_u = 1'b1;
		end
		OP_BEQ, OP_BNE: begin
			ctrl.ren1 = 1'b1;
			ctrl.ren2 = 1'b1;
			ctrl.br_kind = (inst_i.i_t.opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
		end
		OP_BLEZ, OP_BGTZ: begin
			hit = rt_zero;
			ctrl.ren1 = 1'b1;
			ctrl.br_kind = (inst_i.i_t.opcode == OP_BLEZ) ? BR_BLEZ : BR_BGTZ;
		end
		OP_REGIMM: begin
			ctrl.ren1 = 1'b1;
			case (inst_i.i_t.rt)
			RT_BLTZ:   ctrl.br_kind = BR_BLTZ;
			RT_BGEZ:   ctrl.br_kind = BR_BGEZ;
			RT_BLTZAL: begin
				ctrl.br_kind = BR_BLTZ;
				ctrl.is_link = 1'b1;
			end
			RT_BGEZAL: begin
				ctrl.br_kind = BR_BGEZ;
				ctrl.is_link = 1'b1;
			end
			default: hit = 1'b0;
			endcase
		end
		OP_J:  ctrl.br_kind = BR_J;
		OP_JAL: begin
			ctrl.br_kind = BR_J;
			ctrl.is_link = 1'b1;
		end
		default: hit = 1'b0;
		endcase

		// immediate forms write rt and read rs, except lui
		if (ctrl.src2_imm_s | ctrl.src2_imm_u) begin
			ctrl.waddr_rt = 1'b1;
			ctrl.ren1 = (inst_i.i_t.opcode != OP_LUI);
		end
		// link writes pc + 8 into r31 through the adder
		if (ctrl.is_link) begin
			ctrl.alu_op[AOP_ADD] = 1'b1;
			ctrl.src1_pc = 1'b1;
			ctrl.src2_link = 1'b1;
			ctrl.waddr_link = 1'b1;
		end
		ctrl.wr_none = (ctrl.br_kind != BR_NONE) & ~ctrl.is_link;

		if (!hit) begin
			ctrl = '0;
			ctrl.illegal = 1'b1;
		end
		ctrl.valid = 1'b1;
		if (!inst_valid_i)
			ctrl = '0; // no instruction
	end

	assign ctrl_o = ctrl;

endmodule

// ==== src/id_operand_mux.sv ====
`timescale 1ns/1ns

module id_operand_mux (
	input  mips_id_pkg::id_ctrl_t       ctrl_i,
	input  mips_id_pkg::mips_inst_u     inst_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] pc_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] reg1_data_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] reg2_data_i,
	output mips_id_pkg::id_ex_t         next_o
);
	import mips_id_pkg::*;

	logic [XLEN_W-1:0] sa_ext;
	logic [XLEN_W-1:0] imm_s;
	logic [XLEN_W-1:0] imm_u;

	assign sa_ext = {{(XLEN_W-5){1'b0}}, inst_i.r_t.sa};
	assign imm_s  = {{(XLEN_W-16){inst_i.i_t.imm[15]}}, inst_i.i_t.imm};
	assign imm_u  = {{(XLEN_W-16){1'b0}}, inst_i.i_t.imm}; // lui shifted later in execute

	assign next_o.valid   = ctrl_i.valid;
	assign next_o.pc      = pc_i;
	assign next_o.inst    = inst_i;
	assign next_o.rtvalue = reg2_data_i;
	assign next_o.alu_op  = ctrl_i.alu_op;
	assign next_o.illegal = ctrl_i.illegal;

	assign next_o.opr1 = ctrl_i.src1_sa ? sa_ext :
	                     ctrl_i.src1_pc ? pc_i :
	                     reg1_data_i;

	assign next_o.opr2 = ctrl_i.src2_imm_s ? imm_s :
	                     ctrl_i.src2_imm_u ? imm_u :
	                     ctrl_i.src2_link  ? LINK_OFFSET :
	                     reg2_data_i;

	// link beats rt beats rd
	assign next_o.waddr = ctrl_i.waddr_link ? LINK_REG :
	                      ctrl_i.waddr_rt   ? inst_i.i_t.rt :
	                      inst_i.r_t.rd;

	assign next_o.wren = ctrl_i.valid & ~ctrl_i.wr_none & ~ctrl_i.illegal;

endmodule

// ==== src/id_branch_unit.sv ====
`timescale 1ns/1ns

module id_branch_unit (
	input  mips_id_pkg::id_ctrl_t          ctrl_i,
	input  mips_id_pkg::mips_inst_u        inst_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] pc_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] reg1_data_i,
	input  logic [mips_id_pkg::XLEN_W-1:0] reg2_data_i,
	output mips_id_pkg::br_t               br_o
);
	import mips_id_pkg::*;

	logic [XLEN_W-1:0] pc_plus4;
	logic [XLEN_W-1:0] b_target;
	logic [XLEN_W-1:0] j_target;
	logic              eq;
	logic              ltz;
	logic              lez;

	assign pc_plus4 = pc_i + 32'd4;
	assign b_target = pc_plus4 + {{(XLEN_W-18){inst_i.i_t.imm[15]}}, inst_i.i_t.imm, 2'b00};
	assign j_target = {pc_plus4[XLEN_W-1:XLEN_W-4], inst_i.j_t.target, 2'b00}; // same 256MB region

	assign eq  = (reg1_data_i == reg2_data_i);
	assign ltz = reg1_data_i[XLEN_W-1];
	assign lez = ltz | (reg1_data_i == '0);

	always_comb begin
		br_o.is_branch = (ctrl_i.br_kind != BR_NONE);
		br_o.target    = b_target;
		case (ctrl_i.br_kind)
		BR_BEQ:  br_o.taken = eq;
		BR_BNE:  br_o.taken = ~eq;
		BR_BGEZ: br_o.taken = ~ltz;
		BR_BGTZ: br_o.taken = ~lez;
		BR_BLEZ: br_o.taken = lez;
		BR_BLTZ: br_o.taken = ltz;
		BR_J: begin
			br_o.taken  = 1'b1;
			br_o.target = j_target;
		end
		BR_JR: begin
			br_o.taken  = 1'b1;
			br_o.target = reg1_data_i;
		end
		default: br_o.taken = 1'b0; // also covers invalid slots
		endcase
	end

endmodule

// ==== src/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                stall_i,
	input  logic                flush_i,
	input  mips_id_pkg::id_ex_t next_i,
	output mips_id_pkg::id_ex_t ex_o
);

	// stall wins over flush
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_o <= '0;
		end else if (!stall_i) begin
			if (flush_i)
				ex_o <= '0; // bubble
			else
				ex_o <= next_i;
		end
	end

endmodule

// ==== src/id_stage.sv ====
`timescale 1ns/1ns

module id_stage (
	input  logic                               clk,
	input  logic                               rst_n_i,
	input  logic                               stall_i,
	input  logic                               flush_i,
	input  logic                               inst_valid_i,
	input  logic [mips_id_pkg::XLEN_W-1:0]     pc_i,
	input  mips_id_pkg::mips_inst_u            inst_i,
	input  logic [mips_id_pkg::XLEN_W-1:0]     reg1_data_i,
	input  logic [mips_id_pkg::XLEN_W-1:0]     reg2_data_i,
	output logic [mips_id_pkg::REG_ADDR_W-1:0] reg1_addr_o,
	output logic [mips_id_pkg::REG_ADDR_W-1:0] reg2_addr_o,
	output logic                               ren1_o,
	output logic                               ren2_o,
	output mips_id_pkg::br_t                   br_o,
	output mips_id_pkg::id_ex_t                ex_o
);
	import mips_id_pkg::*;

	id_ctrl_t ctrl;
	id_ex_t   ex_next;

	// register file read port, same cycle
	assign reg1_addr_o = inst_i.r_t.rs;
	assign reg2_addr_o = inst_i.r_t.rt;
	assign ren1_o      = ctrl.ren1;
	assign ren2_o      = ctrl.ren2;

	id_field_decode u_decode (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.ctrl_o       (ctrl)
	);

	id_operand_mux u_operand (
		.ctrl_i      (ctrl),
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.next_o      (ex_next)
	);

	id_branch_unit u_branch (
		.ctrl_i      (ctrl),
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.br_o        (br_o)
	);

	id_ex_reg u_id_ex (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.stall_i (stall_i),
		.flush_i (flush_i),
		.next_i  (ex_next),
		.ex_o    (ex_o)
	);

endmodule

// ==== verification/id_stage_asserts.sv ====
`timescale 1ns/1ns

module id_stage_asserts (
	input logic                               clk,
	input logic                               rst_n_i,
	input logic                               stall_i,
	input logic                               flush_i,
	input logic                               inst_valid_i,
	input logic [mips_id_pkg::XLEN_W-1:0]     pc_i,
	input mips_id_pkg::mips_inst_u            inst_i,
	input logic [mips_id_pkg::XLEN_W-1:0]     reg1_data_i,
	input logic [mips_id_pkg::XLEN_W-1:0]     reg2_data_i,
	input logic [mips_id_pkg::REG_ADDR_W-1:0] reg1_addr_i,
	input logic [mips_id_pkg::REG_ADDR_W-1:0] reg2_addr_i,
	input logic                               ren1_i,
	input logic                               ren2_i,
	input mips_id_pkg::br_t                   br_i,
	input mips_id_pkg::id_ex_t                ex_i
);
	import mips_id_pkg::*;

	logic                failed = 1'b0; // set by any failing assertion
	logic [5:0]          op;
	logic [5:0]          fn;
	logic                live;
	logic                cshift;
	logic                r_alu;
	logic                i_alu;
	logic                jr_ok;
	logic                jalr_ok;
	logic                rimm_ok;
	logic                is_br;
	logic                is_link;
	logic                legal;
	logic                exp_ren1;
	logic                exp_ren2;
	logic [ALU_OP_W-1:0] exp_alu;
	logic [XLEN_W-1:0]   imm_s;
	logic [XLEN_W-1:0]   imm_u;
	logic [XLEN_W-1:0]   pc4;
	logic [XLEN_W-1:0]   exp_opr1;
	logic [XLEN_W-1:0]   exp_opr2;
	logic [XLEN_W-1:0]   exp_target;
	logic                exp_taken;

	function automatic logic [ALU_OP_W-1:0] expected_alu(input logic [5:0] op_v,
		input logic [5:0] fn_v);
		logic [ALU_OP_W-1:0] a;
		a = '0;
		if (op_v == OP_SPECIAL) begin
			case (fn_v)
			FN_ADD, FN_ADDU:  a[AOP_ADD] = 1'b1;
			FN_SUB, FN_SUBU:  a[AOP_SUB] = 1'b1;
			FN_SLT:           a[AOP_SLT] = 1'b1;
			FN_SLTU:          a[AOP_SLTU] = 1'b1;
			FN_AND:           a[AOP_AND] = 1'b1;
			FN_OR:            a[AOP_OR] = 1'b1;
			FN_XOR:           a[AOP_XOR] = 1'b1;
			FN_NOR:           a[AOP_NOR] = 1'b1;
			FN_SLL, FN_SLLV:  a[AOP_SLL] = 1'b1;
			FN_SRL, FN_SRLV:  a[AOP_SRL] = 1'b1;
			FN_SRA, FN_SRAV:  a[AOP_SRA] = 1'b1;
			default:          a = '0;
			endcase
		end else begin
			case (op_v)
			OP_ADDI, OP_ADDIU: a[AOP_ADD] = 1'b1;
			OP_SLTI:           a[AOP_SLT] = 1'b1;
			OP_SLTIU:          a[AOP_SLTU] = 1'b1;
			OP_ANDI:           a[AOP_AND] = 1'b1;
			OP_ORI:            a[AOP_OR] = 1'b1;
			OP_XORI:           a[AOP_XOR] = 1'b1;
			OP_LUI:            a[AOP_LUI] = 1'b1;
			default:           a = '0;
			endcase
		end
		return a;
	endfunction

	always_comb begin
		op      = inst_i.r_t.opcode;
		fn      = inst_i.r_t.funct;
		live    = rst_n_i && !stall_i && !flush_i;
		cshift  = (op == OP_SPECIAL) && (fn inside {FN_SLL, FN_SRL, FN_SRA});
		r_alu   = (op == OP_SPECIAL)
		          && (cshift ? (inst_i.r_t.rs == '0) : (inst_i.r_t.sa == '0))
		          && (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
		                         FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA,
		                         FN_SLLV, FN_SRLV, FN_SRAV});
		i_alu   = (op inside {[OP_ADDI:OP_LUI]}) && (op != OP_LUI || inst_i.i_t.rs == '0);
		jr_ok   = (op == OP_SPECIAL) && (fn == FN_JR)
		          && ({inst_i.r_t.rt, inst_i.r_t.rd, inst_i.r_t.sa} == '0);
		jalr_ok = (op == OP_SPECIAL) && (fn == FN_JALR) && ({inst_i.r_t.rt, inst_i.r_t.sa} == '0);
		rimm_ok = (op == OP_REGIMM)
		          && (inst_i.i_t.rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL});
		is_br   = jr_ok || jalr_ok || rimm_ok || (op inside {OP_J, OP_JAL, OP_BEQ, OP_BNE})
		          || ((op inside {OP_BLEZ, OP_BGTZ}) && inst_i.i_t.rt == '0);
		is_link = jalr_ok || (op == OP_JAL) || (rimm_ok && inst_i.i_t.rt[4]);
		legal   = r_alu || i_alu || is_br;
		exp_alu = expected_alu(op, fn);

		// rs is read unless the word uses sa, lui or a jump target
		exp_ren1 = inst_valid_i
		           && ((r_alu && !cshift) || (i_alu && op != OP_LUI) || jr_ok || jalr_ok
		               || rimm_ok || (is_br && op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}));
		exp_ren2 = inst_valid_i && (r_alu || (op inside {OP_BEQ, OP_BNE}));

		imm_s    = {{(XLEN_W-16){inst_i.i_t.imm[15]}}, inst_i.i_t.imm};
		imm_u    = {{(XLEN_W-16){1'b0}}, inst_i.i_t.imm};
		exp_opr1 = cshift ? {{(XLEN_W-5){1'b0}}, inst_i.r_t.sa} : reg1_data_i;
		exp_opr2 = (op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU}) ? imm_s :
		           (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) ? imm_u : reg2_data_i;

		pc4        = pc_i + 4;
		exp_target = pc4 + (imm_s << 2);
		exp_taken  = 1'b1;
		case (op)
		OP_BEQ:    exp_taken = (reg1_data_i == reg2_data_i);
		OP_BNE:    exp_taken = (reg1_data_i != reg2_data_i);
		OP_BLEZ:   exp_taken = ($signed(reg1_data_i) <= 0);
		OP_BGTZ:   exp_taken = ($signed(reg1_data_i) > 0);
		OP_REGIMM: exp_taken = inst_i.i_t.rt[0] ? ($signed(reg1_data_i) >= 0)
		                                        : ($signed(reg1_data_i) < 0);
		OP_J, OP_JAL: exp_target = {pc4[XLEN_W-1:XLEN_W-4], inst_i.j_t.target, 2'b00};
		default:   exp_target = reg1_data_i; // jr and jalr
		endcase
	end

	reg_read: assert property (@(posedge clk)
		reg1_addr_i == inst_i.r_t.rs && reg2_addr_i == inst_i.r_t.rt
		&& ren1_i == exp_ren1 && ren2_i == exp_ren2)
	else begin
		$error("register read port mismatch");
		failed = 1'b1;
	end

	capture: assert property (@(posedge clk) live && inst_valid_i
		|=> ex_i.valid && ex_i.pc == $past(pc_i) && ex_i.inst == $past(inst_i)
		    && ex_i.rtvalue == $past(reg2_data_i))
	else begin
		$error("ex capture mismatch");
		failed = 1'b1;
	end

	alu_decode: assert property (@(posedge clk) live && inst_valid_i && (r_alu || i_alu)
		|=> $onehot(ex_i.alu_op) && ex_i.alu_op == $past(exp_alu) && ex_i.wren
		    && ex_i.waddr == $past(r_alu ? inst_i.r_t.rd : inst_i.i_t.rt))
	else begin
		$error("alu decode or write address mismatch");
		failed = 1'b1;
	end

	operands: assert property (@(posedge clk) live && inst_valid_i && (r_alu || i_alu)
		|=> ex_i.opr1 == $past(exp_opr1) && ex_i.opr2 == $past(exp_opr2))
	else begin
		$error("operand mismatch");
		failed = 1'b1;
	end

	branch: assert property (@(posedge clk) inst_valid_i && is_br
		|-> br_i.is_branch && br_i.taken == exp_taken && br_i.target == exp_target)
	else begin
		$error("branch result mismatch");
		failed = 1'b1;
	end

	branch_no_write: assert property (@(posedge clk) live && inst_valid_i && is_br && !is_link
		|=> !ex_i.wren)
	else begin
		$error("plain branch enabled a write");
		failed = 1'b1;
	end

	link: assert property (@(posedge clk) live && inst_valid_i && is_link
		|=> ex_i.waddr == LINK_REG && ex_i.opr1 == $past(pc_i) && ex_i.opr2 == LINK_OFFSET
		    && ex_i.wren)
	else begin
		$error("link write mismatch");
		failed = 1'b1;
	end

	illegal_ex: assert property (@(posedge clk) live && inst_valid_i && !legal
		|=> ex_i.illegal && !ex_i.wren && ex_i.alu_op == '0)
	else begin
		$error("reserved instruction not flagged");
		failed = 1'b1;
	end

	illegal_br: assert property (@(posedge clk) inst_valid_i && !legal |-> !br_i.is_branch)
	else begin
		$error("reserved instruction seen as branch");
		failed = 1'b1;
	end

	stall_hold: assert property (@(posedge clk) rst_n_i && stall_i |=> $stable(ex_i))
	else begin
		$error("stall did not hold ex");
		failed = 1'b1;
	end

	flush_bubble: assert property (@(posedge clk) rst_n_i && !stall_i && flush_i
		|=> ex_i == '0)
	else begin
		$error("flush did not insert a bubble");
		failed = 1'b1;
	end

	reset_clear: assert property (@(posedge clk) !rst_n_i |=> ex_i == '0)
	else begin
		$error("ex not cleared by reset");
		failed = 1'b1;
	end

	idle_no_take: assert property (@(posedge clk) !inst_valid_i |-> !br_i.taken)
	else begin
		$error("branch taken without an instruction");
		failed = 1'b1;
	end

	idle_no_valid: assert property (@(posedge clk) live && !inst_valid_i |=> !ex_i.valid)
	else begin
		$error("ex valid without an instruction");
		failed = 1'b1;
	end

endmodule

bind id_stage id_stage_asserts u_asserts (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.stall_i      (stall_i),
	.flush_i      (flush_i),
	.inst_valid_i (inst_valid_i),
	.pc_i         (pc_i),
	.inst_i       (inst_i),
	.reg1_data_i  (reg1_data_i),
	.reg2_data_i  (reg2_data_i),
	.reg1_addr_i  (reg1_addr_o),
	.reg2_addr_i  (reg2_addr_o),
	.ren1_i       (ren1_o),
	.ren2_i       (ren2_o),
	.br_i         (br_o),
	.ex_i         (ex_o)
);

// ==== verification/tb_id_stage.sv ====
`timescale 1ns/1ns

module tb_id_stage;
	import mips_id_pkg::*;

	localparam int          N_VECTORS   = 1500;
	localparam int          CYCLE_LIMIT = 2 * N_VECTORS + 200;
	localparam logic [31:0] LFSR_SEED   = 32'd32087;
	localparam logic [31:0] LFSR_TAPS   = 32'hd000_0001;

	localparam logic [5:0] ALU_FUNCTS [16] = '{
		FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV
	};

	logic                  clk;
	logic                  rst_n;
	logic                  stall;
	logic                  flush;
	logic                  inst_valid;
	logic [XLEN_W-1:0]     pc;
	mips_inst_u            inst;
	logic [XLEN_W-1:0]     reg1_data;
	logic [XLEN_W-1:0]     reg2_data;
	logic [REG_ADDR_W-1:0] reg1_addr;
	logic [REG_ADDR_W-1:0] reg2_addr;
	logic                  ren1;
	logic                  ren2;
	br_t                   br;
	id_ex_t                ex;

	logic [31:0]       lfsr;
	logic [XLEN_W-1:0] regfile [32];
	int                stall_left;
	int                flush_left;
	int                idle_left;
	int                cycles;

	id_stage DUT (
		.clk          (clk),
		.rst_n_i      (rst_n),
		.stall_i      (stall),
		.flush_i      (flush),
		.inst_valid_i (inst_valid),
		.pc_i         (pc),
		.inst_i       (inst),
		.reg1_data_i  (reg1_data),
		.reg2_data_i  (reg2_data),
		.reg1_addr_o  (reg1_addr),
		.reg2_addr_o  (reg2_addr),
		.ren1_o       (ren1),
		.ren2_o       (ren2),
		.br_o         (br),
		.ex_o         (ex)
	);

	// register file answers in the same cycle
	assign reg1_data = regfile[reg1_addr];
	assign reg2_data = regfile[reg2_addr];

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		int          k;
		v = '0;
		for (k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] random_inst();
		logic [4:0]  sel;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sa;
		logic [3:0]  fsel;
		logic [15:0] imm;
		logic [5:0]  fn;
		logic [31:0] word;
		sel  = 5'(next_bits(5));
		rs   = 5'(next_bits(5));
		rt   = 5'(next_bits(5));
		rd   = 5'(next_bits(5));
		sa   = 5'(next_bits(5));
		fsel = 4'(next_bits(4));
		imm  = 16'(next_bits(16));
		fn   = ALU_FUNCTS[fsel];
		if (sel < 5'd10) begin
			if (fn inside {FN_SLL, FN_SRL, FN_SRA})
				rs = '0; // constant shift
			else
				sa = '0;
			word = {OP_SPECIAL, rs, rt, rd, sa, fn};
		end else if (sel < 5'd18) begin
			if (sel == 5'd17)
				rs = '0; // lui
			word = {3'b001, 3'(sel - 5'd10), rs, rt, imm};
		end else begin
			case (sel)
			5'd18:        word = {OP_BEQ, rs, rt, imm};
			5'd19:        word = {OP_BNE, rs, rt, imm};
			5'd20:        word = {OP_BLEZ, rs, 5'd0, imm};
			5'd21:        word = {OP_BGTZ, rs, 5'd0, imm};
			5'd22, 5'd23: word = {OP_REGIMM, rs, rt[1], 3'b000, rt[0], imm};
			5'd24:        word = {OP_J, rs, rt, imm};
			5'd25:        word = {OP_JAL, rs, rt, imm};
			5'd26:        word = {OP_SPECIAL, rs, 15'd0, FN_JR};
			5'd27:        word = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
			5'd28, 5'd29: word = {1'b1, sa, rs, rt, imm}; // opcodes 0x20 and up unknown
			default:      word = {OP_SPECIAL, rs, rt, rd, sa, 2'b01, fsel};
			endcase
		end
		return word;
	endfunction

	// short bursts of one to four cycles
	task automatic run_burst(inout int left, output logic active);
		if (left == 0 && next_bits(4) == 0)
			left = 1 + int'(next_bits(2));
		active = (left != 0);
		if (left != 0)
			left--;
	endtask

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		wait (DUT.u_asserts.failed === 1'b1);
		$display("ERR %0t assertion failed", $time);
		$display("RESULT: FAIL");
		$fatal(1, "stopped on assertion failure");
	end

	initial begin
		int   k;
		logic idle;
		lfsr       = LFSR_SEED;
		rst_n      = 1'b0;
		stall      = 1'b0;
		flush      = 1'b0;
		inst_valid = 1'b0;
		pc         = '0;
		inst       = '0;
		stall_left = 0;
		flush_left = 0;
		idle_left  = 0;
		regfile[0] = '0; // r0 reads zero
		for (k = 1; k < 32; k++)
			regfile[k] = next_bits(32);
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		for (k = 0; k < N_VECTORS; k++) begin
			run_burst(stall_left, stall);
			run_burst(flush_left, flush);
			run_burst(idle_left, idle);
			inst_valid = ~idle;
			pc         = {30'(next_bits(30)), 2'b00};
			inst       = random_inst();
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		if (DUT.u_asserts.failed) begin
			$display("RESULT: FAIL");
			$fatal(1, "assertion failure");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

// ==== id_stage.f ====
src/mips_id_pkg.sv
src/id_field_decode.sv
src/id_operand_mux.sv
src/id_branch_unit.sv
src/id_ex_reg.sv
src/id_stage.sv
verification/id_stage_asserts.sv
verification/tb_id_stage.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     ?= tb_id_stage
RTL_TOP    ?= id_stage
FILELIST   ?= id_stage.f
OBJ_DIR    ?= obj_dir
RTL_SRCS   ?= src/mips_id_pkg.sv src/id_field_decode.sv src/id_operand_mux.sv \
              src/id_branch_unit.sv src/id_ex_reg.sv src/id_stage.sv
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing --assert
RUN_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
